/* hdl/am_lock_cfg.svh */
`ifndef AM_LOCK_CFG_SVH
`define AM_LOCK_CFG_SVH

// logical lanes, one marker pattern each
`define AM_N_LANES 20

// 2 sync header bits plus 64 payload bits
`define AM_BLOCK_W 66

// blocks from one marker to the next, 16383 on real hardware
`define AM_SPACING 16

// search and lane timers count 1 .. AM_SPACING
`define AM_TIMER_W 5

`define AM_VALID_CNT_W 5   // lock threshold and valid counter
`define AM_INVALID_CNT_W 3 // unlock threshold and invalid counter

`endif

/* hdl/am_marker_pkg.sv */
`default_nettype none

`include "am_lock_cfg.svh"

package am_marker_pkg;

	typedef logic [4:0] am_lane_t;

	// M0 M1 M2 M4 M5 M6, BIP3 and BIP7 left out
	typedef logic [47:0] am_pattern_t;

	localparam logic [1:0] AM_SYNC_HDR = 2'b10; // control block header

	// M4..M6 are the inverse of M0..M2
	localparam am_pattern_t am_table [`AM_N_LANES] = '{
		48'hC16821_3E97DE, // lane 0
		48'h9D718E_628E71,
		48'h594BE8_A6B417,
		48'h4D957B_B26A84,
		48'hF50709_0AF8F6,
		48'hDD14C2_22EB3D, // lane 5
		48'h9A4A26_65B5D9,
		48'h7B4566_84BA99,
		48'hA02476_5FDB89,
		48'h68C9FB_973604,
		48'hFD6C99_029366, // lane 10
		48'hB99155_466EAA,
		48'h5CB9B2_A3464D,
		48'h1AF8BD_E50742,
		48'h83C7CA_7C3835,
		48'h3536CD_CAC932, // lane 15
		48'hC4314C_3BCEB3,
		48'hADD6B7_522948,
		48'h5F662A_A099D5,
		48'hC0F0E5_3F0F1A  // lane 19
	};

endpackage

`default_nettype wire

/* hdl/am_lock_pkg.sv */
`default_nettype none

package am_lock_pkg;

	// alignment marker lock states
	typedef enum logic [1:0]
	{
		INIT,
		WAIT_1ST,
		WAIT_2ND,
		LOCKED
	} am_lock_state_t;

	// one side of a four-phase req/ack link
	typedef enum logic [1:0]
	{
		IDLE,    // waiting to start a transfer
		HOLD,    // req/ack high, data held
		RELEASE  // handshake winding down
	} link_state_t;

endpackage

`default_nettype wire

/* hdl/block_rx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "am_lock_cfg.svh"

module block_rx import am_lock_pkg::*;
(
	input  logic                   i_clock,
	input  logic                   i_rst,
	input  logic                   i_in_req,
	input  logic [`AM_BLOCK_W-1:0] i_in_block,
	output logic                   o_in_ack,
	input  logic                   i_advance,
	output logic [`AM_BLOCK_W-1:0] o_block,
	output logic                   o_full
);

	link_state_t state;
	logic        full_q;
	logic        accept;

	// take a block only with an empty holder
	assign accept = (state == IDLE) && i_in_req && !full_q;
	assign o_full = full_q;

	always_ff @(posedge i_clock)
	begin
		if (accept)
			o_block <= i_in_block;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			state    <= IDLE;
			o_in_ack <= 1'b0;
			full_q   <= 1'b0;
		end
		else
		begin
			if (accept)
				full_q <= 1'b1;
			else if (i_advance)
				full_q <= 1'b0; // processing took the block

			case (state)
				IDLE:
				begin
					if (accept)
					begin
						o_in_ack <= 1'b1;
						state    <= HOLD;
					end
				end
				HOLD:
				begin
					if (!i_in_req)
					begin
						o_in_ack <= 1'b0;
						state    <= (full_q && !i_advance) ? RELEASE : IDLE;
					end
				end
				RELEASE:
				begin
					// ack is low, holder still busy
					if (i_advance)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/am_comparator.sv */
`timescale 1ns/1ns
`default_nettype none

`include "am_lock_cfg.svh"

module am_comparator import am_marker_pkg::*;
(
	input  logic [`AM_BLOCK_W-1:0] i_block,
	input  logic [`AM_N_LANES-1:0] i_match_mask,
	output logic [`AM_N_LANES-1:0] o_match_vector,
	output logic                   o_am_valid
);

	logic        sync_ok;
	am_pattern_t block_bits;
	logic [`AM_N_LANES-1:0] masked;

	// sync header sits on top of the block
	assign sync_ok = (i_block[`AM_BLOCK_W-1 -: 2] == AM_SYNC_HDR);

	// M0..M2 at [63:40], M4..M6 at [31:8]
	assign block_bits = {i_block[63:40], i_block[31:8]};

	// patterns are distinct, so at most one bit is set
	always_comb
	begin
		for (int i = 0; i < `AM_N_LANES; i++)
		begin
			o_match_vector[i] = sync_ok && (block_bits == am_table[i]);
		end
	end

	// after narrowing only the locked lane survives
	assign masked     = o_match_vector & i_match_mask;
	assign o_am_valid = |masked;

endmodule

`default_nettype wire

/* hdl/am_lock_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

`include "am_lock_cfg.svh"

module am_lock_fsm import am_lock_pkg::*;
(
	input  logic                         i_clock,
	input  logic                         i_rst,
	input  logic                         i_block_lock,
	input  logic                         i_valid,
	input  logic                         i_am_valid,
	input  logic [`AM_N_LANES-1:0]       i_match_vector,
	input  logic [`AM_VALID_CNT_W-1:0]   i_lock_thr,
	input  logic [`AM_INVALID_CNT_W-1:0] i_unlock_thr,
	output logic [`AM_N_LANES-1:0]       o_match_mask,
	output logic                         o_am_lock,
	output logic                         o_start_of_lane,
	output logic                         o_resync
);

	localparam logic [`AM_TIMER_W-1:0] TIMER_END   = `AM_TIMER_W'(`AM_SPACING);
	localparam logic [`AM_TIMER_W-1:0] TIMER_START = `AM_TIMER_W'(1);

	am_lock_state_t state, next_state;

	logic [`AM_N_LANES-1:0]       mask, mask_next;
	logic [`AM_TIMER_W-1:0]       search_timer, lane_timer;
	logic [`AM_VALID_CNT_W-1:0]   valid_cnt, valid_cnt_next;
	logic [`AM_INVALID_CNT_W-1:0] invalid_cnt, invalid_cnt_next, invalid_cnt_inc;
	logic search_done, lane_wrap;
	logic search_restart, lane_restart;
	logic fsm_clear;

	assign fsm_clear       = i_rst || !i_block_lock; // losing block lock acts as reset
	assign search_done     = (search_timer == TIMER_END);
	assign lane_wrap       = (lane_timer == TIMER_END);
	assign invalid_cnt_inc = invalid_cnt + 1'b1;

	assign o_match_mask = mask;
	assign o_am_lock    = (state == LOCKED);

	always_comb
	begin
		next_state       = state;
		mask_next        = mask;
		valid_cnt_next   = '0;
		invalid_cnt_next = '0;
		search_restart   = 1'b0;
		lane_restart     = 1'b0;

		case (state)
			INIT:
			begin
				mask_next  = '1;
				next_state = WAIT_1ST;
			end
			WAIT_1ST:
			begin
				if (i_am_valid)
				begin
					mask_next      = i_match_vector; // narrow to the lane just seen
					search_restart = 1'b1;
					next_state     = WAIT_2ND;
				end
			end
			WAIT_2ND:
			begin
				valid_cnt_next = valid_cnt;
				if (search_done && i_am_valid)
				begin
					if (valid_cnt == i_lock_thr)
					begin
						lane_restart = 1'b1;
						next_state   = LOCKED;
					end
					else
					begin
						valid_cnt_next = valid_cnt + 1'b1;
					end
				end
				else if (search_done)
				begin
					// marker missing at the expected spot
					mask_next  = '1;
					next_state = WAIT_1ST;
				end
			end
			LOCKED:
			begin
				invalid_cnt_next = invalid_cnt;
				if (search_done && i_am_valid)
				begin
					invalid_cnt_next = '0;
				end
				else if (search_done)
				begin
					if (invalid_cnt_inc >= i_unlock_thr)
					begin
						mask_next  = '1;
						next_state = WAIT_1ST;
					end
					else
					begin
						invalid_cnt_next = invalid_cnt_inc;
					end
				end
			end
			default: next_state = INIT;
		endcase
	end

	always_ff @(posedge i_clock)
	begin
		if (fsm_clear)
		begin
			state           <= INIT;
			mask            <= '1;
			valid_cnt       <= '0;
			invalid_cnt     <= '0;
			search_timer    <= TIMER_START;
			lane_timer      <= TIMER_START;
			o_start_of_lane <= 1'b0;
		end
		else if (i_valid)
		begin
			state       <= next_state;
			mask        <= mask_next;
			valid_cnt   <= valid_cnt_next;
			invalid_cnt <= invalid_cnt_next;

			// both timers count blocks and wrap at the marker spacing
			search_timer <= (search_restart || search_done) ? TIMER_START : search_timer + 1'b1;
			lane_timer   <= (lane_restart || lane_wrap) ? TIMER_START : lane_timer + 1'b1;

			// flags the block one full period after the lock point
			o_start_of_lane <= lane_wrap && (state == LOCKED) && (next_state == LOCKED);
		end
	end

	// one cycle pulse when locking moves the lane boundary
	always_ff @(posedge i_clock)
	begin
		if (fsm_clear)
			o_resync <= 1'b0;
		else
			o_resync <= i_valid && lane_restart && (lane_timer != search_timer);
	end

endmodule

`default_nettype wire

/* hdl/lane_tx.sv */
`timescale 1ns/1ns
`default_nettype none

`include "am_lock_cfg.svh"

module lane_tx import am_lock_pkg::*, am_marker_pkg::*;
(
	input  logic                   i_clock,
	input  logic                   i_rst,
	input  logic                   i_load,
	input  logic [`AM_BLOCK_W-1:0] i_block,
	input  logic                   i_am_lock,
	input  logic                   i_start_of_lane,
	input  logic [`AM_N_LANES-1:0] i_match_mask,
	output logic                   o_empty,
	output logic                   o_out_req,
	input  logic                   i_out_ack,
	output logic [`AM_BLOCK_W-1:0] o_out_block,
	output logic                   o_out_am_lock,
	output logic                   o_out_start_of_lane,
	output am_lane_t               o_out_lane
);

	link_state_t state;
	logic        pending; // block loaded, status not sampled yet

	// one-hot mask to lane index
	function automatic am_lane_t encode_lane(input logic [`AM_N_LANES-1:0] mask);
		am_lane_t lane;
		lane = '0;
		for (int i = 0; i < `AM_N_LANES; i++)
		begin
			if (mask[i])
				lane = am_lane_t'(i);
		end
		return lane;
	endfunction

	assign o_empty = (state == IDLE) && !pending;

	always_ff @(posedge i_clock)
	begin
		if (i_load)
			o_out_block <= i_block;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_rst)
		begin
			state               <= IDLE;
			pending             <= 1'b0;
			o_out_req           <= 1'b0;
			o_out_am_lock       <= 1'b0;
			o_out_start_of_lane <= 1'b0;
			o_out_lane          <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (pending)
					begin
						// FSM now shows the status of this block
						o_out_am_lock       <= i_am_lock;
						o_out_start_of_lane <= i_start_of_lane;
						o_out_lane          <= i_am_lock ? encode_lane(i_match_mask) : '0;
						o_out_req           <= 1'b1;
						pending             <= 1'b0;
						state               <= HOLD;
					end
					else if (i_load)
						pending <= 1'b1;
				end
				HOLD:
				begin
					if (i_out_ack)
					begin
						o_out_req <= 1'b0;
						state     <= RELEASE;
					end
				end
				RELEASE:
				begin
					if (!i_out_ack)
						state <= IDLE; // sink done
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/am_lock_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "am_lock_cfg.svh"

module am_lock_top import am_marker_pkg::*;
(
	input  logic                         i_clock,
	input  logic                         i_rst,
	input  logic                         i_block_lock,
	input  logic [`AM_VALID_CNT_W-1:0]   i_lock_thr,
	input  logic [`AM_INVALID_CNT_W-1:0] i_unlock_thr,
	input  logic                         i_in_req,
	input  logic [`AM_BLOCK_W-1:0]       i_in_block,
	output logic                         o_in_ack,
	output logic                         o_out_req,
	input  logic                         i_out_ack,
	output logic [`AM_BLOCK_W-1:0]       o_out_block,
	output logic                         o_out_am_lock,
	output logic                         o_out_start_of_lane,
	output am_lane_t                     o_out_lane,
	output logic                         o_resync
);

	logic                   advance;
	logic                   rx_full, tx_empty;
	logic [`AM_BLOCK_W-1:0] held_block;
	logic [`AM_N_LANES-1:0] match_vector, match_mask;
	logic                   am_valid, am_lock, start_of_lane;

	// single enable for the processing part
	assign advance = rx_full && tx_empty;

	block_rx u_block_rx (
		.i_clock    (i_clock),
		.i_rst      (i_rst),
		.i_in_req   (i_in_req),
		.i_in_block (i_in_block),
		.o_in_ack   (o_in_ack),
		.i_advance  (advance),
		.o_block    (held_block),
		.o_full     (rx_full)
	);

	am_comparator u_am_comparator (
		.i_block        (held_block),
		.i_match_mask   (match_mask),
		.o_match_vector (match_vector),
		.o_am_valid     (am_valid)
	);

	am_lock_fsm u_am_lock_fsm (
		.i_clock         (i_clock),
		.i_rst           (i_rst),
		.i_block_lock    (i_block_lock),
		.i_valid         (advance),
		.i_am_valid      (am_valid),
		.i_match_vector  (match_vector),
		.i_lock_thr      (i_lock_thr),
		.i_unlock_thr    (i_unlock_thr),
		.o_match_mask    (match_mask),
		.o_am_lock       (am_lock),
		.o_start_of_lane (start_of_lane),
		.o_resync        (o_resync)
	);

	lane_tx u_lane_tx (
		.i_clock             (i_clock),
		.i_rst               (i_rst),
		.i_load              (advance),
		.i_block             (held_block),
		.i_am_lock           (am_lock),
		.i_start_of_lane     (start_of_lane),
		.i_match_mask        (match_mask),
		.o_empty             (tx_empty),
		.o_out_req           (o_out_req),
		.i_out_ack           (i_out_ack),
		.o_out_block         (o_out_block),
		.o_out_am_lock       (o_out_am_lock),
		.o_out_start_of_lane (o_out_start_of_lane),
		.o_out_lane          (o_out_lane)
	);

endmodule

`default_nettype wire

/* verif/am_lock_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "am_lock_cfg.svh"

module am_lock_checker import am_marker_pkg::*;
(
	input  logic                   i_clock,
	input  logic                   i_rst,
	input  logic                   i_in_req,
	input  logic [`AM_BLOCK_W-1:0] i_in_block,
	input  logic                   o_in_ack,
	input  logic                   o_out_req,
	input  logic                   i_out_ack,
	input  logic [`AM_BLOCK_W-1:0] o_out_block,
	input  logic                   o_out_am_lock,
	input  logic                   o_out_start_of_lane,
	input  am_lane_t               o_out_lane,
	input  logic                   am_lock,
	input  logic [`AM_N_LANES-1:0] match_mask
);

	// four-phase ordering on both links
	in_req_order: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(i_in_req) |-> !o_in_ack) else $error("input req rose with ack high");
	in_ack_order: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(o_in_ack) |-> i_in_req) else $error("input ack rose without req");
	out_req_order: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(o_out_req) |-> !i_out_ack) else $error("output req rose with ack high");
	out_ack_order: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(i_out_ack) |-> o_out_req) else $error("output ack rose without req");

	// data held while req is up
	in_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_in_req && $past(i_in_req)) |-> $stable(i_in_block))
		else $error("input block changed under req");
	out_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		(o_out_req && $past(o_out_req)) |-> ($stable(o_out_block) && $stable(o_out_lane)
		&& $stable(o_out_am_lock) && $stable(o_out_start_of_lane)))
		else $error("output changed under req");

	mask_onehot: assert property (@(posedge i_clock) disable iff (i_rst)
		am_lock |-> $onehot(match_mask)) else $error("lock with mask not one-hot");
	sol_locked: assert property (@(posedge i_clock) disable iff (i_rst)
		o_out_start_of_lane |-> o_out_am_lock) else $error("start of lane while unlocked");

endmodule

bind am_lock_top am_lock_checker u_checker (
	.i_clock             (i_clock),
	.i_rst               (i_rst),
	.i_in_req            (i_in_req),
	.i_in_block          (i_in_block),
	.o_in_ack            (o_in_ack),
	.o_out_req           (o_out_req),
	.i_out_ack           (i_out_ack),
	.o_out_block         (o_out_block),
	.o_out_am_lock       (o_out_am_lock),
	.o_out_start_of_lane (o_out_start_of_lane),
	.o_out_lane          (o_out_lane),
	.am_lock             (am_lock),
	.match_mask          (match_mask)
);

`default_nettype wire

/* verif/am_lock_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "am_lock_cfg.svh"

module am_lock_tb import am_marker_pkg::*;
();

	localparam int WAIT_LIMIT  = 1000;   // cycles per handshake wait
	localparam int CYCLE_LIMIT = 200000; // whole run
	localparam logic [`AM_VALID_CNT_W-1:0]   LOCK_THR   = 2;
	localparam logic [`AM_INVALID_CNT_W-1:0] UNLOCK_THR = 3;

	logic                   i_clock;
	logic                   i_rst;
	logic                   i_block_lock;
	logic                   i_in_req;
	logic [`AM_BLOCK_W-1:0] i_in_block;
	logic                   o_in_ack;
	logic                   o_out_req;
	logic                   i_out_ack;
	logic [`AM_BLOCK_W-1:0] o_out_block;
	logic                   o_out_am_lock;
	logic                   o_out_start_of_lane;
	am_lane_t               o_out_lane;
	logic                   o_resync;

	logic [31:0] lfsr = 32'hd63d;
	int errors = 0;
	int timeouts = 0;
	int locked_outputs = 0;
	int resync_exp = 0;
	int resync_seen = 0;
	logic done = 1'b0;
	logic abort = 1'b0;

	// expected and received traffic with status packed as {lock, sol, lane}
	logic [`AM_BLOCK_W-1:0] exp_block[$];
	logic [6:0]             exp_status[$];
	logic [`AM_BLOCK_W-1:0] got_block[$];
	logic [6:0]             got_status[$];

	// reference model of the marker lock
	int m_state; // 0 init, 1 wait first, 2 wait second, 3 locked
	logic [`AM_N_LANES-1:0] m_mask;
	int m_vcnt, m_icnt, m_search, m_lane;

	am_lock_top UUT (
		.i_clock             (i_clock),
		.i_rst               (i_rst),
		.i_block_lock        (i_block_lock),
		.i_lock_thr          (LOCK_THR),
		.i_unlock_thr        (UNLOCK_THR),
		.i_in_req            (i_in_req),
		.i_in_block          (i_in_block),
		.o_in_ack            (o_in_ack),
		.o_out_req           (o_out_req),
		.i_out_ack           (i_out_ack),
		.o_out_block         (o_out_block),
		.o_out_am_lock       (o_out_am_lock),
		.o_out_start_of_lane (o_out_start_of_lane),
		.o_out_lane          (o_out_lane),
		.o_resync            (o_resync)
	);

	initial
	begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	// galois lfsr stepped once per bit
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r    = {r[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic void model_reset();
		m_state  = 0;
		m_mask   = '1;
		m_vcnt   = 0;
		m_icnt   = 0;
		m_search = 1;
		m_lane   = 1;
	endfunction

	// expected {lock, start-of-lane, lane} after one block
	function automatic logic [6:0] expected_status(input logic [`AM_BLOCK_W-1:0] blk);
		logic [`AM_N_LANES-1:0] mv, nmask;
		logic valid, sdone, lwrap, srestart, lrestart, sol;
		int nstate, nv, ni;
		logic [4:0] lane;
		for (int i = 0; i < `AM_N_LANES; i++)
			mv[i] = (blk[65:64] == 2'b10) && ({blk[63:40], blk[31:8]} == am_table[i]);
		valid    = |(mv & m_mask);
		sdone    = (m_search == `AM_SPACING);
		lwrap    = (m_lane == `AM_SPACING);
		nstate   = m_state;
		nmask    = m_mask;
		nv       = 0;
		ni       = 0;
		srestart = 1'b0;
		lrestart = 1'b0;
		case (m_state)
			0:
			begin
				nmask  = '1;
				nstate = 1;
			end
			1:
			begin
				if (valid)
				begin
					nmask    = mv;
					srestart = 1'b1;
					nstate   = 2;
				end
			end
			2:
			begin
				nv = m_vcnt;
				if (sdone && valid)
				begin
					if (m_vcnt == int'(LOCK_THR))
					begin
						lrestart = 1'b1;
						nstate   = 3;
					end
					else
						nv = m_vcnt + 1;
				end
				else if (sdone)
				begin
					nmask  = '1; // marker missing
					nstate = 1;
				end
			end
			default:
			begin
				ni = m_icnt;
				if (sdone && valid)
					ni = 0;
				else if (sdone)
				begin
					if (m_icnt + 1 >= int'(UNLOCK_THR))
					begin
						nmask  = '1;
						nstate = 1;
					end
					else
						ni = m_icnt + 1;
				end
			end
		endcase
		if (lrestart && (m_lane != m_search))
			resync_exp++; // lock point moves the lane boundary
		sol      = lwrap && (m_state == 3) && (nstate == 3);
		m_search = (srestart || sdone) ? 1 : m_search + 1;
		m_lane   = (lrestart || lwrap) ? 1 : m_lane + 1;
		m_state  = nstate;
		m_mask   = nmask;
		m_vcnt   = nv;
		m_icnt   = ni;
		lane     = '0;
		if (nstate == 3)
			for (int i = 0; i < `AM_N_LANES; i++)
				if (nmask[i])
					lane = 5'(i);
		return {(nstate == 3), sol, lane};
	endfunction

	task automatic check_value(input string name, input logic [65:0] got,
		input logic [65:0] exp);
		if (got !== exp)
		begin
			$display("Mismatch %s: got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_in_ack(input logic level);
		int cnt;
		cnt = 0;
		while (o_in_ack !== level && !abort)
		begin
			@(negedge i_clock);
			cnt++;
			if (cnt > WAIT_LIMIT)
			begin
				$display("input ack did not reach %0b in time", level);
				timeouts++;
				abort = 1'b1;
			end
		end
	endtask

	task automatic send_block(input logic [`AM_BLOCK_W-1:0] blk);
		exp_block.push_back(blk);
		exp_status.push_back(expected_status(blk));
		@(posedge i_clock);
		i_in_req   <= 1'b1;
		i_in_block <= blk;
		wait_in_ack(1'b1);
		@(posedge i_clock);
		i_in_req <= 1'b0;
		wait_in_ack(1'b0);
		repeat (rand_bits(2)) @(posedge i_clock); // source gap
	endtask

	// one marker period with a marker or filler first
	task automatic send_period(input int lane, input logic marker, input int len);
		logic [7:0] bip3, bip7;
		bip3 = 8'(rand_bits(8));
		bip7 = 8'(rand_bits(8));
		if (marker)
			send_block({2'b10, am_table[lane][47:24], bip3, am_table[lane][23:0], bip7});
		else
			send_block({2'b01, rand_bits(64)});
		for (int i = 1; i < len; i++)
			send_block({2'b01, rand_bits(64)});
	endtask

	task automatic drain();
		int cnt;
		cnt = 0;
		while (exp_block.size() != 0 && !abort)
		begin
			@(negedge i_clock);
			cnt++;
			if (cnt > WAIT_LIMIT)
			begin
				$display("output did not deliver all sent blocks");
				timeouts++;
				abort = 1'b1;
			end
		end
	endtask

	task automatic drop_block_lock();
		drain();
		@(posedge i_clock);
		i_block_lock <= 1'b0;
		repeat (2) @(posedge i_clock);
		i_block_lock <= 1'b1;
		@(posedge i_clock);
		model_reset();
	endtask

	// stimulus
	initial
	begin
		int lane_a, lane_b;
		i_rst        = 1'b1;
		i_block_lock = 1'b1;
		i_in_req     = 1'b0;
		i_in_block   = '0;
		model_reset();
		repeat (5) @(posedge i_clock);
		i_rst <= 1'b0;
		lane_a = int'(rand_bits(5)) % `AM_N_LANES;
		lane_b = (lane_a + 1 + int'(rand_bits(5)) % 19) % `AM_N_LANES;
		for (int i = 0; i < 5; i++)
			send_block({2'b01, rand_bits(64)});
		repeat (6) send_period(lane_a, 1'b1, `AM_SPACING);
		repeat (2) send_period(lane_a, 1'b0, `AM_SPACING); // short gap keeps lock
		repeat (2) send_period(lane_a, 1'b1, `AM_SPACING);
		repeat (3) send_period(lane_a, 1'b0, `AM_SPACING); // unlock
		repeat (6) send_period(lane_a, 1'b1, `AM_SPACING);
		drop_block_lock();
		repeat (6) send_period(lane_b, 1'b1, `AM_SPACING);
		drop_block_lock();
		repeat (6) send_period(lane_b, 1'b1, 13); // wrong spacing
		for (int i = 0; i < 6; i++)
			send_period((i % 2) ? lane_a : lane_b, 1'b1, `AM_SPACING);
		drain();
		check_value("locked_outputs_seen", 66'(locked_outputs > 0), 66'(1));
		check_value("o_resync", 66'(resync_seen), 66'(resync_exp));
		done = 1'b1;
	end

	// sink with random ack delays
	initial
	begin
		int cnt;
		i_out_ack = 1'b0;
		while (!done && !abort)
		begin
			cnt = 0;
			while (o_out_req !== 1'b1 && !done && !abort)
			begin
				@(negedge i_clock);
				cnt++;
				if (cnt > WAIT_LIMIT)
				begin
					$display("output req never rose");
					timeouts++;
					abort = 1'b1;
				end
			end
			if (o_out_req === 1'b1 && !abort)
			begin
				got_block.push_back(o_out_block);
				got_status.push_back({o_out_am_lock, o_out_start_of_lane, o_out_lane});
				repeat (rand_bits(3)) @(posedge i_clock);
				@(posedge i_clock);
				i_out_ack <= 1'b1;
				cnt = 0;
				while (o_out_req !== 1'b0 && !abort)
				begin
					@(negedge i_clock);
					cnt++;
					if (cnt > WAIT_LIMIT)
					begin
						$display("output req stayed high after ack");
						timeouts++;
						abort = 1'b1;
					end
				end
				repeat (rand_bits(2)) @(posedge i_clock);
				@(posedge i_clock);
				i_out_ack <= 1'b0;
				@(negedge i_clock);
			end
		end
	end

	// compare process
	initial
	begin
		logic [`AM_BLOCK_W-1:0] blk;
		logic [6:0] st, exp_st;
		forever
		begin
			@(negedge i_clock);
			while (got_block.size() != 0)
			begin
				blk = got_block.pop_front();
				st  = got_status.pop_front();
				if (exp_block.size() == 0)
				begin
					$display("output block arrived with nothing sent");
					errors++;
				end
				else
				begin
					exp_st = exp_status.pop_front();
					check_value("o_out_block", 66'(blk), 66'(exp_block.pop_front()));
					check_value("o_out_am_lock", 66'(st[6]), 66'(exp_st[6]));
					check_value("o_out_start_of_lane", 66'(st[5]), 66'(exp_st[5]));
					check_value("o_out_lane", 66'(st[4:0]), 66'(exp_st[4:0]));
					if (st[6])
						locked_outputs++;
				end
			end
		end
	end

	// resync pulses last one cycle
	always @(negedge i_clock)
	begin
		if (o_resync === 1'b1)
			resync_seen++;
	end

	// end of run
	initial
	begin
		int cyc;
		cyc = 0;
		while (!done && !abort && cyc < CYCLE_LIMIT)
		begin
			@(posedge i_clock);
			cyc++;
		end
		if (cyc >= CYCLE_LIMIT)
		begin
			$display("run exceeded its cycle limit");
			timeouts++;
		end
		$display("result: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+hdl
hdl/am_marker_pkg.sv
hdl/am_lock_pkg.sv
hdl/block_rx.sv
hdl/am_comparator.sv
hdl/am_lock_fsm.sv
hdl/lane_tx.sv
hdl/am_lock_top.sv
verif/am_lock_checker.sv
verif/am_lock_tb.sv

/* run.sh */
#!/bin/bash
# build and run the am_lock testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module am_lock_tb -f all.f -o am_lock_sim

./obj_dir/am_lock_sim 2>&1 | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
